// ==== hw/zx_io_pkg.sv ====
package zx_io_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] addr_t;

  // raw z80 pins, all strobes active low
  typedef struct packed {
    logic  iorq_n;
    logic  rd_n;
    logic  wr_n;
    logic  m1_n;
    addr_t a;
  } z80_pins_t;

  typedef struct packed {
    logic  iowr_s;  // one fclk per write cycle
    logic  iord_s;  // one fclk per read cycle
    logic  iord;
    logic  intack;
    addr_t port_a;
  } io_strobe_t;

  typedef logic [2:0] border_t;
  typedef logic [1:0] turbo_t;

  typedef struct packed {
    logic [4:0] rsvd;
    logic       tape_sound;
    turbo_t     turbo;
  } sysconf_t;

  typedef struct packed {
    logic [5:0] rsvd;
    logic       line_en;
    logic       frame_en;
  } intmask_t;

  // one written byte, meaning depends on port
  typedef union packed {
    byte_t    raw;
    sysconf_t conf;
    intmask_t mask;
  } io_data_u;

  // ula port is selected by a0 low only
  localparam byte_t ULA_PORT_LO = 8'hFE;
  localparam byte_t XT_PORT_LO  = 8'hAF;
  localparam byte_t XT_SYSCONF  = 8'h20;
  localparam byte_t XT_INTMASK  = 8'h2A;

  localparam byte_t VECT_FRAME = 8'hFF;
  localparam byte_t VECT_LINE  = 8'hFD;

  localparam int INT_LEN_DEF = 32;  // fclk cycles

  localparam byte_t FE_READ_IDLE = 8'hBF;  // bit 6 is tape

endpackage

// ==== hw/z80_bus_sync.sv ====
`timescale 1ns/1ns

module z80_bus_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                  fclk,
  input  logic                  rst,
  input  zx_io_pkg::z80_pins_t  bus,
  output zx_io_pkg::io_strobe_t strb
);

  // {iorq_n, rd_n, wr_n, m1_n} per stage, newest in [0]
  logic [SYNC_STAGES-1:0][3:0] pin_sync;

  logic iorq, rd, wr, m1;
  logic iowr_lvl, iord_lvl, ack_lvl;
  logic iowr_prev, iord_prev;
  logic iowr_p, iord_p, ack_q;
  zx_io_pkg::addr_t port_q;

  always_ff @(posedge fclk) begin
    if (rst) begin
      pin_sync <= '1;  // all strobes idle
    end else begin
      pin_sync <= {pin_sync[SYNC_STAGES-2:0], {bus.iorq_n, bus.rd_n, bus.wr_n, bus.m1_n}};
    end
  end

  assign {iorq, rd, wr, m1} = ~pin_sync[SYNC_STAGES-1];

  assign iowr_lvl = iorq & ~m1 & wr;
  assign iord_lvl = iorq & ~m1 & rd;
  assign ack_lvl  = iorq & m1;  // im2 acknowledge cycle

  always_ff @(posedge fclk) begin
    if (rst) begin
      iowr_prev <= 1'b0;
      iord_prev <= 1'b0;
      iowr_p    <= 1'b0;
      iord_p    <= 1'b0;
      ack_q     <= 1'b0;
    end else begin
      iowr_prev <= iowr_lvl;
      iord_prev <= iord_lvl;
      iowr_p    <= iowr_lvl & ~iowr_prev;  // rising edge only
      iord_p    <= iord_lvl & ~iord_prev;
      ack_q     <= ack_lvl;
    end
  end

  // address is long stable by now, hold it for the whole access
  always_ff @(posedge fclk) begin
    if ((iowr_lvl & ~iowr_prev) | (iord_lvl & ~iord_prev)) begin
      port_q <= bus.a;
    end
  end

  assign strb = '{iowr_s: iowr_p, iord_s: iord_p, iord: iord_prev,
                  intack: ack_q, port_a: port_q};

  a_rd_wr_excl: assert property (@(posedge fclk) disable iff (rst)
    !(strb.iowr_s && strb.iord_s));

endmodule

// ==== hw/io_port_regs.sv ====
`timescale 1ns/1ns

module io_port_regs (
  input  logic                  fclk,
  input  logic                  rst,
  input  zx_io_pkg::io_strobe_t strb,
  input  zx_io_pkg::byte_t      d_in,
  input  logic                  tape_bit,
  output zx_io_pkg::byte_t      d_out,
  output logic                  d_oe,
  output zx_io_pkg::border_t    border,
  output zx_io_pkg::turbo_t     turbo,
  output logic                  tape_sound,
  output zx_io_pkg::intmask_t   int_mask,
  output logic                  beeper_wr,
  output logic                  beeper_bit
);

  zx_io_pkg::io_data_u wdata;
  zx_io_pkg::sysconf_t sysconf;

  logic ula_hit;
  logic sysconf_hit;
  logic intmask_hit;
  logic ula_wr;

  assign wdata = d_in;

  // partial decode, any even port is #FE
  assign ula_hit     = strb.port_a[0] == zx_io_pkg::ULA_PORT_LO[0];
  assign sysconf_hit = strb.port_a == {zx_io_pkg::XT_SYSCONF, zx_io_pkg::XT_PORT_LO};
  assign intmask_hit = strb.port_a == {zx_io_pkg::XT_INTMASK, zx_io_pkg::XT_PORT_LO};

  assign ula_wr = strb.iowr_s & ula_hit;

  always_ff @(posedge fclk) begin
    if (rst) begin
      border    <= '0;
      sysconf   <= '0;
      int_mask  <= '0;
      beeper_wr <= 1'b0;
    end else begin
      beeper_wr <= ula_wr;
      if (ula_wr) begin
        border <= wdata.raw[2:0];
      end
      if (strb.iowr_s & sysconf_hit) begin
        sysconf <= wdata.conf;
      end
      if (strb.iowr_s & intmask_hit) begin
        int_mask <= wdata.mask;
      end
    end
  end

  always_ff @(posedge fclk) begin
    if (ula_wr) begin
      beeper_bit <= wdata.raw[4];  // ear/speaker bit
    end
  end

  assign turbo      = sysconf.turbo;
  assign tape_sound = sysconf.tape_sound;

  // #FE read, keyboard lines idle high
  assign d_oe  = strb.iord & ula_hit;
  assign d_out = {zx_io_pkg::FE_READ_IDLE[7], tape_bit, zx_io_pkg::FE_READ_IDLE[5:0]};

  a_no_drive_on_wr: assert property (@(posedge fclk) disable iff (rst)
    !(d_oe && strb.iowr_s));

endmodule

// ==== hw/int_ctrl.sv ====
`timescale 1ns/1ns

module int_ctrl #(
  parameter int INT_LEN = 32
) (
  input  logic                  fclk,
  input  logic                  rst,
  input  zx_io_pkg::io_strobe_t strb,
  input  zx_io_pkg::intmask_t   int_mask,
  input  logic                  frame_start,
  input  logic                  line_start,
  output logic                  int_n,
  output zx_io_pkg::byte_t      d_out,
  output logic                  d_oe
);

  localparam int CW = (INT_LEN > 1) ? $clog2(INT_LEN) : 1;

  logic [CW-1:0] cnt;
  logic pend_frm, pend_lin;
  logic int_act;
  logic ack_d;
  logic serve_frm;  // source chosen at ack start

  logic sel_frm;
  logic ack_end;
  logic int_done;
  logic clr_frm, clr_lin;
  logic int_go;

  // frame wins, and the choice is frozen once ack is under way
  assign sel_frm = ack_d ? serve_frm : pend_frm;

  assign ack_end  = ack_d & ~strb.intack;
  assign int_done = int_act & ~strb.intack & (cnt == CW'(INT_LEN - 1));  // cpu missed it

  assign clr_frm = (ack_end | int_done) & sel_frm;
  assign clr_lin = (ack_end | int_done) & ~sel_frm;

  assign int_go = (pend_frm | pend_lin) & ~int_act & ~strb.intack & ~ack_d;

  always_ff @(posedge fclk) begin
    if (rst) begin
      pend_frm <= 1'b0;
      pend_lin <= 1'b0;
      int_act  <= 1'b0;
      ack_d    <= 1'b0;
      cnt      <= '0;
    end else begin
      ack_d    <= strb.intack;
      pend_frm <= (pend_frm & ~clr_frm) | (frame_start & int_mask.frame_en);
      pend_lin <= (pend_lin & ~clr_lin) | (line_start & int_mask.line_en);
      if (int_go) begin
        int_act <= 1'b1;
        cnt     <= '0;
      end else if (int_done | strb.intack) begin
        int_act <= 1'b0;
      end else if (int_act) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge fclk) begin
    if (strb.intack) begin
      serve_frm <= sel_frm;
    end
  end

  assign int_n = ~int_act;

  assign d_oe  = strb.intack & (pend_frm | pend_lin);
  assign d_out = sel_frm ? zx_io_pkg::VECT_FRAME : zx_io_pkg::VECT_LINE;

  // vector on the bus belongs to a source that is still pending
  a_vect_pending: assert property (@(posedge fclk) disable iff (rst)
    d_oe |-> (sel_frm ? pend_frm : pend_lin));

  a_int_has_src: assert property (@(posedge fclk) disable iff (rst)
    !int_n |-> (pend_frm || pend_lin));

endmodule

// ==== hw/beeper_out.sv ====
`timescale 1ns/1ns

module beeper_out #(
  parameter int SYNC_STAGES = 2
) (
  input  logic fclk,
  input  logic rst,
  input  logic beeper_wr,
  input  logic beeper_bit,
  input  logic tape_sound,
  input  logic tape_in,
  output logic tape_bit,
  output logic beep
);

  logic [SYNC_STAGES-1:0] tape_sync;
  logic beep_q;     // last written beeper bit
  logic beep_next;

  always_ff @(posedge fclk) begin
    if (rst) begin
      tape_sync <= '0;
    end else begin
      tape_sync <= {tape_sync[SYNC_STAGES-2:0], tape_in};
    end
  end

  assign tape_bit = tape_sync[SYNC_STAGES-1];

  assign beep_next = beeper_wr ? beeper_bit : beep_q;

  always_ff @(posedge fclk) begin
    if (rst) begin
      beep_q <= 1'b0;
      beep   <= 1'b0;
    end else begin
      beep_q <= beep_next;
      beep   <= beep_next ^ (tape_sound & tape_bit);  // tape mixed in on request
    end
  end

endmodule

// ==== hw/zx_io_top.sv ====
`timescale 1ns/1ns

module zx_io_top #(
  parameter int SYNC_STAGES = 2,
  parameter int INT_LEN     = zx_io_pkg::INT_LEN_DEF
) (
  input  logic                 fclk,
  input  logic                 rst,
  input  zx_io_pkg::z80_pins_t bus,
  input  zx_io_pkg::byte_t     d_in,
  input  logic                 frame_start,
  input  logic                 line_start,
  input  logic                 tape_in,
  output zx_io_pkg::byte_t     d_out,
  output logic                 d_oe,
  output logic                 int_n,
  output logic                 beep,
  output zx_io_pkg::border_t   border,
  output zx_io_pkg::turbo_t    turbo
);

  zx_io_pkg::io_strobe_t strb;
  zx_io_pkg::intmask_t   int_mask;
  zx_io_pkg::byte_t      port_dout;
  zx_io_pkg::byte_t      vect_dout;
  logic port_oe, vect_oe;
  logic beeper_wr, beeper_bit, tape_sound, tape_bit;

  z80_bus_sync #(.SYNC_STAGES(SYNC_STAGES)) u_sync (
    .fclk(fclk), .rst(rst), .bus(bus), .strb(strb)
  );

  io_port_regs u_ports (
    .fclk(fclk), .rst(rst), .strb(strb), .d_in(d_in), .tape_bit(tape_bit),
    .d_out(port_dout), .d_oe(port_oe), .border(border), .turbo(turbo),
    .tape_sound(tape_sound), .int_mask(int_mask),
    .beeper_wr(beeper_wr), .beeper_bit(beeper_bit)
  );

  int_ctrl #(.INT_LEN(INT_LEN)) u_int (
    .fclk(fclk), .rst(rst), .strb(strb), .int_mask(int_mask),
    .frame_start(frame_start), .line_start(line_start),
    .int_n(int_n), .d_out(vect_dout), .d_oe(vect_oe)
  );

  beeper_out #(.SYNC_STAGES(SYNC_STAGES)) u_beep (
    .fclk(fclk), .rst(rst), .beeper_wr(beeper_wr), .beeper_bit(beeper_bit),
    .tape_sound(tape_sound), .tape_in(tape_in), .tape_bit(tape_bit), .beep(beep)
  );

  // im2 vector has the bus during acknowledge
  assign d_out = vect_oe ? vect_dout : port_dout;
  assign d_oe  = vect_oe | port_oe;

endmodule

// ==== bench/zx_io_tb.sv ====
`timescale 1ns/1ns

module zx_io_tb;

  localparam int SYNC_STAGES = 2;
  localparam int INT_LEN     = zx_io_pkg::INT_LEN_DEF;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_PULSE, OP_ACK, OP_TAPE, OP_EXPIRE} op_e;

  typedef struct packed {
    op_e                op;
    zx_io_pkg::addr_t   addr;
    zx_io_pkg::byte_t   data;
    zx_io_pkg::byte_t   fill;  // bits taken from the random byte
    zx_io_pkg::byte_t   exp_byte;
    zx_io_pkg::border_t exp_border;
    zx_io_pkg::turbo_t  exp_turbo;
    logic               exp_int_n;
    logic               exp_beep;
  } entry_t;

  logic fclk, rst, frame_start, line_start, tape_in;
  logic d_oe, int_n, beep;
  zx_io_pkg::z80_pins_t bus;
  zx_io_pkg::byte_t     d_in, d_out;
  zx_io_pkg::border_t   border;
  zx_io_pkg::turbo_t    turbo;

  entry_t table_q[$];
  integer seed;
  int value_errs, other_errs, cur, cycles, cycle_limit;

  zx_io_top #(.SYNC_STAGES(SYNC_STAGES), .INT_LEN(INT_LEN)) dut (
    .fclk(fclk), .rst(rst), .bus(bus), .d_in(d_in), .frame_start(frame_start),
    .line_start(line_start), .tape_in(tape_in), .d_out(d_out), .d_oe(d_oe),
    .int_n(int_n), .beep(beep), .border(border), .turbo(turbo)
  );

  always #50 fclk = ~fclk;

  always @(posedge fclk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("run stopped by the cycle limit after %0d cycles", cycles);
      $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
      $display("=== FAIL ===");
      $finish;
    end
  end

  task automatic check_byte(input string name, input zx_io_pkg::byte_t got,
                            input zx_io_pkg::byte_t exp);
    if (got !== exp) begin
      $display("[ERROR] entry %0d %s: got %h, expected %h", cur, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_border(input string name, input zx_io_pkg::border_t got,
                              input zx_io_pkg::border_t exp);
    if (got !== exp) begin
      $display("[ERROR] entry %0d %s: got %h, expected %h", cur, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_turbo(input string name, input zx_io_pkg::turbo_t got,
                             input zx_io_pkg::turbo_t exp);
    if (got !== exp) begin
      $display("[ERROR] entry %0d %s: got %h, expected %h", cur, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] entry %0d %s: got %h, expected %h", cur, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic report(input string what);
    $display("entry %0d: %s", cur, what);
    other_errs++;
  endtask

  task automatic add_entry(input op_e op, input zx_io_pkg::addr_t a, input zx_io_pkg::byte_t d,
                           input zx_io_pkg::byte_t f, input zx_io_pkg::byte_t eb,
                           input zx_io_pkg::border_t bo, input zx_io_pkg::turbo_t tu,
                           input logic in, input logic be);
    entry_t e;
    e = '{op, a, d, f, eb, bo, tu, in, be};
    table_q.push_back(e);
  endtask

  // starts and ends on a falling edge
  task automatic bus_access(input zx_io_pkg::addr_t a, input zx_io_pkg::byte_t d,
                            input logic rd, input logic wr, input logic ack,
                            output zx_io_pkg::byte_t seen, output logic oe_seen);
    bus.a      = a;
    d_in       = d;
    bus.iorq_n = 1'b0;
    bus.rd_n   = ~rd;
    bus.wr_n   = ~wr;
    bus.m1_n   = ~ack;  // m1 low with iorq is the im2 acknowledge
    oe_seen    = 1'b0;
    repeat (8) begin
      @(negedge fclk);
      oe_seen = oe_seen | (d_oe === 1'b1);
    end
    seen       = d_out;
    bus.iorq_n = 1'b1;
    bus.rd_n   = 1'b1;
    bus.wr_n   = 1'b1;
    bus.m1_n   = 1'b1;
    repeat (4) @(negedge fclk);
  endtask

  task automatic wait_int_low();
    int n;
    n = 0;
    while (int_n !== 1'b0 && n < INT_LEN) begin
      @(negedge fclk);
      n++;
    end
    if (int_n !== 1'b0) report("interrupt never asserted within INT_LEN cycles");
  endtask

  task automatic pulse_sources(input zx_io_pkg::byte_t src);
    frame_start = src[0];
    line_start  = src[1];
    @(negedge fclk);
    frame_start = 1'b0;
    line_start  = 1'b0;
  endtask

  task automatic apply_entry(input entry_t e);
    zx_io_pkg::byte_t rnd, drv, seen;
    logic oe_seen;
    int n;
    rnd = $random(seed);
    drv = (e.data & ~e.fill) | (rnd & e.fill);
    case (e.op)
      OP_WR: bus_access(e.addr, drv, 1'b0, 1'b1, 1'b0, seen, oe_seen);
      OP_RD: begin
        bus_access(e.addr, drv, 1'b1, 1'b0, 1'b0, seen, oe_seen);
        if (!oe_seen) report("d_oe did not rise during the #FE read");
        else check_byte("d_out", seen, e.exp_byte);
      end
      OP_ACK: begin
        bus_access(e.addr, drv, 1'b0, 1'b0, 1'b1, seen, oe_seen);
        if (!oe_seen) report("d_oe did not rise during acknowledge");
        else check_byte("d_out", seen, e.exp_byte);
        if (!e.exp_int_n) wait_int_low();  // next source still pending
      end
      OP_PULSE: begin
        pulse_sources(e.data);
        if (!e.exp_int_n) wait_int_low();
        else repeat (4) @(negedge fclk);
      end
      OP_TAPE: begin
        tape_in = e.data[0];
        repeat (SYNC_STAGES + 2) @(negedge fclk);
      end
      default: begin
        pulse_sources(8'h01);
        wait_int_low();
        n = 0;
        while (int_n === 1'b0 && n < INT_LEN + 2) begin
          @(negedge fclk);
          n++;
        end
        if (int_n === 1'b0) report("int_n stayed low longer than INT_LEN+2 cycles");
      end
    endcase
    check_border("border", border, e.exp_border);
    check_turbo("turbo", turbo, e.exp_turbo);
    check_level("int_n", int_n, e.exp_int_n);
    check_level("beep", beep, e.exp_beep);
    check_level("d_oe", d_oe, 1'b0);
  endtask

  initial begin
    seed        = 32'h3e3d;
    fclk        = 1'b0;
    rst         = 1'b1;
    bus         = '{iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1, m1_n: 1'b1, a: '0};
    d_in        = '0;
    frame_start = 1'b0;
    line_start  = 1'b0;
    tape_in     = 1'b0;
    // op  addr  data  fill  d_out  border  turbo  int_n  beep
    add_entry(OP_WR,     16'h00FE, 8'h15, 8'hE8, 8'h00, 3'd5, 2'd0, 1'b1, 1'b1);
    add_entry(OP_WR,     16'h00FE, 8'h02, 8'hE8, 8'h00, 3'd2, 2'd0, 1'b1, 1'b0);
    add_entry(OP_WR,     16'h00FD, 8'h15, 8'hE8, 8'h00, 3'd2, 2'd0, 1'b1, 1'b0);
    add_entry(OP_WR,     16'h2BAF, 8'h03, 8'hFC, 8'h00, 3'd2, 2'd0, 1'b1, 1'b0);
    add_entry(OP_WR,     16'h20AF, 8'h07, 8'hF8, 8'h00, 3'd2, 2'd3, 1'b1, 1'b0);
    add_entry(OP_TAPE,   16'h0000, 8'h01, 8'h00, 8'h00, 3'd2, 2'd3, 1'b1, 1'b1);
    add_entry(OP_WR,     16'h00FE, 8'h13, 8'hE8, 8'h00, 3'd3, 2'd3, 1'b1, 1'b0);
    add_entry(OP_RD,     16'h00FE, 8'h00, 8'h00, 8'hFF, 3'd3, 2'd3, 1'b1, 1'b0);
    add_entry(OP_TAPE,   16'h0000, 8'h00, 8'h00, 8'h00, 3'd3, 2'd3, 1'b1, 1'b1);
    add_entry(OP_RD,     16'hFBFE, 8'h00, 8'h00, 8'hBF, 3'd3, 2'd3, 1'b1, 1'b1);
    add_entry(OP_WR,     16'h20AF, 8'h01, 8'hF8, 8'h00, 3'd3, 2'd1, 1'b1, 1'b1);
    add_entry(OP_TAPE,   16'h0000, 8'h01, 8'h00, 8'h00, 3'd3, 2'd1, 1'b1, 1'b1);
    add_entry(OP_WR,     16'h2AAF, 8'h01, 8'hFC, 8'h00, 3'd3, 2'd1, 1'b1, 1'b1);
    add_entry(OP_PULSE,  16'h0000, 8'h01, 8'h00, 8'h00, 3'd3, 2'd1, 1'b0, 1'b1);
    add_entry(OP_ACK,    16'h00FF, 8'h00, 8'h00, 8'hFF, 3'd3, 2'd1, 1'b1, 1'b1);
    add_entry(OP_PULSE,  16'h0000, 8'h02, 8'h00, 8'h00, 3'd3, 2'd1, 1'b1, 1'b1);
    add_entry(OP_WR,     16'h2AAF, 8'h03, 8'hFC, 8'h00, 3'd3, 2'd1, 1'b1, 1'b1);
    add_entry(OP_PULSE,  16'h0000, 8'h03, 8'h00, 8'h00, 3'd3, 2'd1, 1'b0, 1'b1);
    add_entry(OP_ACK,    16'h00FF, 8'h00, 8'h00, 8'hFF, 3'd3, 2'd1, 1'b0, 1'b1);
    add_entry(OP_ACK,    16'h00FF, 8'h00, 8'h00, 8'hFD, 3'd3, 2'd1, 1'b1, 1'b1);
    add_entry(OP_WR,     16'h2AAF, 8'h01, 8'hFC, 8'h00, 3'd3, 2'd1, 1'b1, 1'b1);
    add_entry(OP_EXPIRE, 16'h0000, 8'h00, 8'h00, 8'h00, 3'd3, 2'd1, 1'b1, 1'b1);
    cycle_limit = table_q.size() * 20 + 200;
    repeat (2) @(posedge fclk);
    @(negedge fclk);
    rst = 1'b0;
    cur = 0;
    check_level("int_n", int_n, 1'b1);
    check_level("beep", beep, 1'b0);
    check_border("border", border, 3'd0);
    check_turbo("turbo", turbo, 2'd0);
    check_level("d_oe", d_oe, 1'b0);
    foreach (table_q[i]) begin
      cur = i + 1;
      apply_entry(table_q[i]);
    end
    repeat (2) @(negedge fclk);
    $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/zx_io_pkg.sv
hw/z80_bus_sync.sv
hw/io_port_regs.sv
hw/int_ctrl.sv
hw/beeper_out.sv
hw/zx_io_top.sv
bench/zx_io_tb.sv

// ==== Bender.yml ====
package:
  name: zx_io

sources:
  - hw/zx_io_pkg.sv
  - hw/z80_bus_sync.sv
  - hw/io_port_regs.sv
  - hw/int_ctrl.sv
  - hw/beeper_out.sv
  - hw/zx_io_top.sv
  - target: test
    files:
      - bench/zx_io_tb.sv
